//--- Bender.yml
package:
  name: neoBusGlue

sources:
  - source/neoBusPkg.sv
  - source/busZoneDecode.sv
  - source/memStrobeGen.sv
  - source/sysLatchRegs.sv
  - source/ioReadMux.sv
  - source/neoBusGlue.sv
  - target: test
    files:
      - verification/neoBusGlueTb.sv

//--- neoBusGlue.f
source/neoBusPkg.sv
source/busZoneDecode.sv
source/memStrobeGen.sv
source/sysLatchRegs.sv
source/ioReadMux.sv
source/neoBusGlue.sv
verification/neoBusGlueTb.sv

//--- source/busZoneDecode.sv
`timescale 1ns/1ps

module busZoneDecode
(
	input  neoBusPkg::cpuAddr_u   cpuAddr,
	input  logic                  nAs,        // Address strobe
	output neoBusPkg::busZone_e   zone,
	output neoBusPkg::latchFunc_e latchFunc,
	output logic                  setClear
);

	logic [3:0] nibble;  // A23..A20
	logic [2:0] ioSel;   // A19..A17, splits the 0x3x page

	assign nibble = cpuAddr.mem.region[4:1];
	assign ioSel  = {cpuAddr.mem.region[0], cpuAddr.mem.offset[17:16]};

	// Zone compare on the upper address bits
	always_comb
	begin
		zone = neoBusPkg::zoneNone;
		if (!nAs)
		begin
			case (nibble)
				4'h0: zone = neoBusPkg::zoneRom;
				4'h1: zone = neoBusPkg::zoneWram;
				4'h2: zone = neoBusPkg::zonePort;
				4'h3:
				begin
					// I/O page, A23..A18 plus A17 for the latch
					casez (ioSel)
						3'b00?:  zone = neoBusPkg::zoneCtrl1;
						3'b01?:  zone = neoBusPkg::zoneCtrl2;
						3'b100:  zone = neoBusPkg::zoneStatusB;
						3'b101:  zone = neoBusPkg::zoneSysLatch;
						default: zone = neoBusPkg::zoneNone;  // 0x3C video, not here
					endcase
				end
				4'hC: zone = neoBusPkg::zoneSysRom;
				4'hD: zone = neoBusPkg::zoneSram;
				default: zone = neoBusPkg::zoneNone;
			endcase
		end
	end

	// Latch view of the same word
	assign latchFunc = neoBusPkg::latchFunc_e'(cpuAddr.latch.func);
	assign setClear  = cpuAddr.latch.setClear;

	// Latch zone only inside a bus cycle
	sysLatchIdle: assert final (!(nAs && zone == neoBusPkg::zoneSysLatch))
		else $error("System latch zone decoded with nAs high");

endmodule

//--- source/ioReadMux.sv
`timescale 1ns/1ps

module ioReadMux
(
	input  neoBusPkg::busZone_e zone,
	input  logic                rw,          // High for read
	input  logic                nAs,
	input  logic                nWp,         // Memory card write protect
	input  logic                nCd1,        // Card detect
	input  logic                nCd2,
	input  logic                systemMode,  // High for MVS
	input  logic [9:0]          p1In,        // Start and select in bits 9:8
	input  logic [9:0]          p2In,
	input  logic [7:0]          dipSwitch,
	output logic [15:0]         cpuDataOut,
	output logic                dataOutEnable
);

	logic readCycle;

	assign readCycle = ~nAs & rw;

	always_comb
	begin
		cpuDataOut    = 16'hFFFF;  // Undriven bus reads high
		dataOutEnable = 1'b0;
		if (readCycle)
		begin
			case (zone)
				neoBusPkg::zoneCtrl1:
				begin
					cpuDataOut    = {p1In[7:0], dipSwitch};
					dataOutEnable = 1'b1;
				end
				neoBusPkg::zoneCtrl2:
				begin
					cpuDataOut    = {p2In[7:0], 8'hFF};
					dataOutEnable = 1'b1;
				end
				neoBusPkg::zoneStatusB:
				begin
					// Card status, start/select pairs and board type
					cpuDataOut    = {nWp, nCd2, nCd1, p2In[9:8], p1In[9:8], systemMode, 8'hFF};
					dataOutEnable = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- source/memStrobeGen.sv
`timescale 1ns/1ps

module memStrobeGen
(
	input  neoBusPkg::busZone_e zone,
	input  logic                rw,          // High for read
	input  logic                nLds,        // Lower lane, D7..D0
	input  logic                nUds,        // Upper lane, D15..D8
	input  logic                sramLocked,
	output logic                nRomOe,
	output logic                nWramRdLow,
	output logic                nWramRdHigh,
	output logic                nWramWrLow,
	output logic                nWramWrHigh,
	output logic                nPortOeLow,
	output logic                nPortOeHigh,
	output logic                nPortWeLow,
	output logic                nPortWeHigh,
	output logic                nSramOeLow,
	output logic                nSramOeHigh,
	output logic                nSramWeLow,
	output logic                nSramWeHigh,
	output logic                nSysRomOe
);

	logic lowLane;
	logic highLane;
	logic anyLane;
	logic rdRom, rdSysRom;
	logic rdWram, wrWram;
	logic rdPort, wrPort;
	logic rdSram, wrSram;

	assign lowLane  = ~nLds;
	assign highLane = ~nUds;
	assign anyLane  = lowLane | highLane;  // Word wide ROMs

	// Zone and direction qualifiers
	assign rdRom    = (zone == neoBusPkg::zoneRom) & rw;
	assign rdSysRom = (zone == neoBusPkg::zoneSysRom) & rw;
	assign rdWram   = (zone == neoBusPkg::zoneWram) & rw;
	assign wrWram   = (zone == neoBusPkg::zoneWram) & ~rw;
	assign rdPort   = (zone == neoBusPkg::zonePort) & rw;
	assign wrPort   = (zone == neoBusPkg::zonePort) & ~rw;
	assign rdSram   = (zone == neoBusPkg::zoneSram) & rw;
	assign wrSram   = (zone == neoBusPkg::zoneSram) & ~rw & ~sramLocked;  // Lock masks both lanes

	assign nRomOe      = ~(rdRom & anyLane);
	assign nSysRomOe   = ~(rdSysRom & anyLane);
	assign nWramRdLow  = ~(rdWram & lowLane);
	assign nWramRdHigh = ~(rdWram & highLane);
	assign nWramWrLow  = ~(wrWram & lowLane);
	assign nWramWrHigh = ~(wrWram & highLane);
	assign nPortOeLow  = ~(rdPort & lowLane);
	assign nPortOeHigh = ~(rdPort & highLane);
	assign nPortWeLow  = ~(wrPort & lowLane);
	assign nPortWeHigh = ~(wrPort & highLane);
	assign nSramOeLow  = ~(rdSram & lowLane);
	assign nSramOeHigh = ~(rdSram & highLane);
	assign nSramWeLow  = ~(wrSram & lowLane);
	assign nSramWeHigh = ~(wrSram & highLane);

	// Lock bit comes from the system latch
	sramLockHolds: assert final (!(sramLocked && !(nSramWeLow && nSramWeHigh)))
		else $error("SRAM write strobe active while SRAM locked");

endmodule

//--- source/neoBusGlue.sv
`timescale 1ns/1ps

module neoBusGlue
#(
	parameter int watchdogLimit = neoBusPkg::watchdogLimitDefault
)
(
	input  logic                MCLK,
	input  logic                reset,
	input  neoBusPkg::cpuAddr_u cpuAddr,
	input  logic [15:0]         cpuDataIn,
	input  logic                rw,
	input  logic                nAs,
	input  logic                nLds,
	input  logic                nUds,
	input  logic                nWp,
	input  logic                nCd1,
	input  logic                nCd2,
	input  logic                systemMode,
	input  logic [9:0]          p1In,
	input  logic [9:0]          p2In,
	input  logic [7:0]          dipSwitch,
	output logic                nRomOe,
	output logic                nWramRdLow,
	output logic                nWramRdHigh,
	output logic                nWramWrLow,
	output logic                nWramWrHigh,
	output logic                nPortOeLow,
	output logic                nPortOeHigh,
	output logic                nPortWeLow,
	output logic                nPortWeHigh,
	output logic                nSramOeLow,
	output logic                nSramOeHigh,
	output logic                nSramWeLow,
	output logic                nSramWeHigh,
	output logic                nSysRomOe,
	output logic                systemVectors,
	output logic                nSystem,
	output logic [7:0]          ledData,
	output logic [3:0]          coinOut,
	output logic                watchdogReset,
	output logic [15:0]         cpuDataOut,
	output logic                dataOutEnable
);

	neoBusPkg::busZone_e   zone;
	neoBusPkg::latchFunc_e latchFunc;
	neoBusPkg::ledFunc_e   ledSelect;
	logic                  setClear;
	logic                  sramLocked;  // System latch to SRAM strobes

	assign ledSelect = neoBusPkg::ledFunc_e'(cpuAddr.mem.offset[5:3]);  // A6..A4

	// Ports connect by name
	busZoneDecode busZoneDecode_i (.*);
	memStrobeGen memStrobeGen_i (.*);
	sysLatchRegs #(.watchdogLimit(watchdogLimit)) sysLatchRegs_i (.*);
	ioReadMux ioReadMux_i (.*);

endmodule

//--- source/neoBusPkg.sv
package neoBusPkg;

	// CPU address zones, zoneNone when idle or unmapped
	typedef enum logic [3:0] {
		zoneNone     = 4'd0,
		zoneRom      = 4'd1,  // 0x000000 cartridge P ROM
		zoneWram     = 4'd2,  // 0x100000 work RAM
		zonePort     = 4'd3,  // 0x200000 cartridge port
		zoneCtrl1    = 4'd4,  // 0x300000 P1 and DIP, watchdog kick
		zoneCtrl2    = 4'd5,  // 0x340000 P2
		zoneStatusB  = 4'd6,  // 0x380000 status, LED and coin latches
		zoneSysLatch = 4'd7,  // 0x3A0000 system latch
		zoneSysRom   = 4'd8,  // 0xC00000 system ROM
		zoneSram     = 4'd9   // 0xD00000 battery SRAM
	} busZone_e;

	// 68000 word address 23:1 with two readings
	typedef union packed {
		struct packed {
			logic [4:0]  region;    // A23..A19
			logic [17:0] offset;    // A18..A1
		} mem;
		struct packed {
			logic [18:0] upper;     // A23..A5
			logic        setClear;  // A4, new bit value
			logic [2:0]  func;      // A3..A1, bit select
		} latch;
	} cpuAddr_u;

	// System latch bit select at 0x3A0000
	typedef enum logic [2:0] {
		funcVectors  = 3'd1,
		funcFix      = 3'd5,
		funcSramLock = 3'd6
	} latchFunc_e;

	// Output latch select from A6..A4 in the status B zone
	typedef enum logic [2:0] {
		ledCoin = 3'd1,
		ledData = 3'd3
	} ledFunc_e;

	// Watchdog length in MCLK cycles
	parameter int watchdogLimitDefault = 16384;

endpackage

//--- source/sysLatchRegs.sv
`timescale 1ns/1ps

module sysLatchRegs
#(
	parameter int watchdogLimit = neoBusPkg::watchdogLimitDefault
)
(
	input  logic                  MCLK,
	input  logic                  reset,
	input  logic                  nAs,
	input  logic                  rw,             // High for read
	input  neoBusPkg::busZone_e   zone,
	input  neoBusPkg::latchFunc_e latchFunc,
	input  logic                  setClear,
	input  neoBusPkg::ledFunc_e   ledSelect,      // A6..A4
	input  logic [15:0]           cpuDataIn,
	output logic                  sramLocked,
	output logic                  systemVectors,  // High maps BIOS vectors
	output logic                  nSystem,        // Low selects system fix ROM
	output logic [7:0]            ledData,
	output logic [3:0]            coinOut,
	output logic                  watchdogReset
);

	localparam int wdWidth = $clog2(watchdogLimit + 1);

	logic               nAsPrev;     // nAs at the previous edge
	logic               writeStart;  // First edge of a write cycle
	logic               wdKick;
	logic [wdWidth-1:0] wdCount;

	always_ff @(posedge MCLK)
	begin
		if (reset)
			nAsPrev <= 1'b1;
		else
			nAsPrev <= nAs;
	end

	assign writeStart = ~nAs & nAsPrev & ~rw;  // One action per bus cycle
	assign wdKick     = writeStart & (zone == neoBusPkg::zoneCtrl1);

	// System latch at 0x3A0000, A4 gives the value
	always_ff @(posedge MCLK)
	begin
		if (reset)
		begin
			sramLocked    <= 1'b1;
			systemVectors <= 1'b1;
			nSystem       <= 1'b0;
		end
		else if (writeStart && zone == neoBusPkg::zoneSysLatch)
		begin
			case (latchFunc)
				neoBusPkg::funcVectors:  systemVectors <= ~setClear;
				neoBusPkg::funcFix:      nSystem <= setClear;
				neoBusPkg::funcSramLock: sramLocked <= ~setClear;
				default: ;  // Other latch bits not modelled
			endcase
		end
	end

	// Cabinet LED and coin counter latches
	always_ff @(posedge MCLK)
	begin
		if (reset)
		begin
			ledData <= 8'h00;
			coinOut <= 4'h0;
		end
		else if (writeStart && zone == neoBusPkg::zoneStatusB)
		begin
			case (ledSelect)
				neoBusPkg::ledData: ledData <= cpuDataIn[7:0];
				neoBusPkg::ledCoin: coinOut <= cpuDataIn[3:0];
				default: ;
			endcase
		end
	end

	// Watchdog, restarts from 0 after each pulse
	always_ff @(posedge MCLK)
	begin
		if (reset || wdKick)
		begin
			wdCount       <= '0;
			watchdogReset <= 1'b0;
		end
		else if (wdCount == wdWidth'(watchdogLimit - 1))
		begin
			wdCount       <= '0;
			watchdogReset <= 1'b1;
		end
		else
		begin
			wdCount       <= wdCount + 1'b1;
			watchdogReset <= 1'b0;
		end
	end

	wdPulseSingle: assert property (@(posedge MCLK) disable iff (reset)
		watchdogReset |=> !watchdogReset)
		else $error("watchdogReset high for more than one cycle");

endmodule

//--- verification/neoBusGlueTb.sv
`timescale 1ns/1ps

module neoBusGlueTb;

	localparam int wdLimit    = 64;
	localparam int cycleLimit = 2000;  // Tests take roughly 500 cycles

	logic                MCLK;
	logic                reset;
	neoBusPkg::cpuAddr_u cpuAddr;
	logic [15:0]         cpuDataIn;
	logic                rw;
	logic                nAs;
	logic                nLds;
	logic                nUds;
	logic                nWp;
	logic                nCd1;
	logic                nCd2;
	logic                systemMode;
	logic [9:0]          p1In;
	logic [9:0]          p2In;
	logic [7:0]          dipSwitch;
	logic [13:0]         strobes;  // nRomOe at bit 13 down to nSysRomOe at bit 0
	logic                systemVectors;
	logic                nSystem;
	logic [7:0]          ledData;
	logic [3:0]          coinOut;
	logic                watchdogReset;
	logic [15:0]         cpuDataOut;
	logic                dataOutEnable;

	int                  errors   = 0;
	int                  checks   = 0;
	int                  cycles   = 0;
	logic [31:0]         lcgState = 32'h5839_0c88;
	logic [13:0]         seenStrobes;  // Captured at the rising edge inside a bus cycle
	logic [15:0]         seenData;
	logic                seenOe;
	neoBusPkg::busZone_e seenZone;

	neoBusGlue #(.watchdogLimit(wdLimit)) neoBusGlue_i
	(
		.*,
		.nRomOe(strobes[13]), .nWramRdLow(strobes[12]), .nWramRdHigh(strobes[11]),
		.nWramWrLow(strobes[10]), .nWramWrHigh(strobes[9]), .nPortOeLow(strobes[8]),
		.nPortOeHigh(strobes[7]), .nPortWeLow(strobes[6]), .nPortWeHigh(strobes[5]),
		.nSramOeLow(strobes[4]), .nSramOeHigh(strobes[3]), .nSramWeLow(strobes[2]),
		.nSramWeHigh(strobes[1]), .nSysRomOe(strobes[0])
	);

	always #20 MCLK = ~MCLK;  // 40 ns period

	always @(posedge MCLK)
	begin
		cycles <= cycles + 1;
		if (cycles == cycleLimit)
		begin
			$display("Timeout: tests still running after %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Zone of a byte address from the memory map
	function automatic neoBusPkg::busZone_e zoneOf(input logic [23:0] a);
		case (a[23:20])
			4'h0: return neoBusPkg::zoneRom;
			4'h1: return neoBusPkg::zoneWram;
			4'h2: return neoBusPkg::zonePort;
			4'h3:
			begin
				case (a[19:17])
					3'b000, 3'b001: return neoBusPkg::zoneCtrl1;
					3'b010, 3'b011: return neoBusPkg::zoneCtrl2;
					3'b100: return neoBusPkg::zoneStatusB;
					3'b101: return neoBusPkg::zoneSysLatch;
					default: return neoBusPkg::zoneNone;
				endcase
			end
			4'hC: return neoBusPkg::zoneSysRom;
			4'hD: return neoBusPkg::zoneSram;
			default: return neoBusPkg::zoneNone;
		endcase
	endfunction

	// One low strobe per active lane and one ROM strobe for any lane
	function automatic logic [13:0] expectStrobes(input neoBusPkg::busZone_e z, input logic rd,
		input logic [1:0] lanes, input logic locked);
		logic [13:0] s;
		logic [3:0]  pair;  // RdLow, RdHigh, WrLow, WrHigh
		s    = 14'h3FFF;
		pair = rd ? {~lanes[0], ~lanes[1], 2'b11} : {2'b11, ~lanes[0], ~lanes[1]};
		case (z)
			neoBusPkg::zoneRom:    s[13] = ~(rd & |lanes);
			neoBusPkg::zoneWram:   s[12:9] = pair;
			neoBusPkg::zonePort:   s[8:5] = pair;
			neoBusPkg::zoneSram:   s[4:1] = (!rd && locked) ? 4'hF : pair;
			neoBusPkg::zoneSysRom: s[0] = ~(rd & |lanes);
			default: ;
		endcase
		return s;
	endfunction

	task automatic checkZone(input string name, input neoBusPkg::busZone_e got,
		input neoBusPkg::busZone_e exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkStrobes(input string name, input logic [13:0] got, input logic [13:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	// One CPU bus cycle with nAs low for one full clock
	task automatic busCycle(input logic [23:0] byteAddr, input logic rdNotWr,
		input logic [1:0] lanes, input logic [15:0] data);
		@(negedge MCLK);
		cpuAddr   = byteAddr[23:1];  // Word address since A0 has no pin
		cpuDataIn = data;
		{rw, nUds, nLds, nAs} = {rdNotWr, ~lanes[1], ~lanes[0], 1'b0};
		@(posedge MCLK);  // Register writes take effect at this edge
		seenStrobes = strobes;
		seenZone    = neoBusGlue_i.zone;
		seenData    = cpuDataOut;
		seenOe      = dataOutEnable;
		@(negedge MCLK);
		{nAs, rw, nLds, nUds} = 4'hF;
	endtask

	task automatic cpuRead(input logic [23:0] byteAddr, input logic [1:0] lanes);
		busCycle(byteAddr, 1'b1, lanes, 16'hFFFF);
	endtask

	task automatic cpuWrite(input logic [23:0] byteAddr, input logic [1:0] lanes,
		input logic [15:0] data);
		busCycle(byteAddr, 1'b0, lanes, data);
	endtask

	// ROM, WRAM, port, system ROM and SRAM on every lane and direction
	task automatic testStrobes();
		logic [19:0] nibbles;
		logic [23:0] a;
		nibbles = 20'h012CD;
		for (int b = 0; b < 5; b++)
			for (int d = 0; d < 2; d++)
				for (int l = 1; l < 4; l++)
				begin
					a = {nibbles[4*(4-b) +: 4], 20'(nextRand())};
					if (d == 1)
						cpuRead(a, l[1:0]);
					else
						cpuWrite(a, l[1:0], 16'h0000);
					checkZone("zone", seenZone, zoneOf(a));
					checkStrobes("strobes", seenStrobes,
						expectStrobes(zoneOf(a), d[0], l[1:0], 1'b1));
					@(negedge MCLK);
					{rw, nUds, nLds} = {d[0], ~l[1], ~l[0]};  // Lanes and rw held with nAs high
					@(posedge MCLK);
					checkStrobes("idle strobes", strobes, 14'h3FFF);
					@(negedge MCLK);
					{rw, nLds, nUds} = 3'b111;
				end
	endtask

	task automatic testSramLock();
		cpuWrite(24'hD00000, 2'b11, 16'h1234);
		checkStrobes("strobes locked SRAM write", seenStrobes, 14'h3FFF);
		cpuWrite(24'h3A001D, 2'b01, 16'h0000);  // Unlock
		cpuWrite(24'hD00010, 2'b11, 16'h5678);
		checkStrobes("strobes unlocked SRAM word write", seenStrobes, 14'h3FF9);
		cpuWrite(24'hD00021, 2'b01, 16'h009A);
		checkStrobes("strobes unlocked SRAM low write", seenStrobes, 14'h3FFB);
		cpuWrite(24'h3A000D, 2'b01, 16'h0000);  // Lock again
		cpuWrite(24'hD00030, 2'b11, 16'hBCDE);
		checkStrobes("strobes relocked SRAM write", seenStrobes, 14'h3FFF);
	endtask

	task automatic testInputs();
		logic [31:0] r;
		repeat (4)
		begin
			@(negedge MCLK);
			r          = nextRand();
			p1In       = r[9:0];
			p2In       = r[19:10];
			dipSwitch  = r[27:20];
			{nWp, nCd1, nCd2, systemMode} = r[31:28];
			cpuRead(24'h300000, 2'b11);
			checkWord("ctrl1 cpuDataOut", seenData, {p1In[7:0], dipSwitch});
			checkBit("ctrl1 dataOutEnable", seenOe, 1'b1);
			cpuRead(24'h340000, 2'b11);
			checkWord("ctrl2 cpuDataOut", seenData, {p2In[7:0], 8'hFF});
			cpuRead(24'h380000, 2'b11);
			checkWord("status cpuDataOut", seenData,
				{nWp, nCd2, nCd1, p2In[9:8], p1In[9:8], systemMode, 8'hFF});
		end
	endtask

	task automatic testLatches();
		logic [15:0] ledWord;
		logic [15:0] coinWord;
		checkBit("systemVectors after reset", systemVectors, 1'b1);
		checkBit("nSystem after reset", nSystem, 1'b0);
		checkWord("ledData after reset", {8'h00, ledData}, 16'h0000);
		checkWord("coinOut after reset", {12'h000, coinOut}, 16'h0000);
		cpuWrite(24'h3A0013, 2'b01, 16'h0000);
		checkBit("systemVectors cleared", systemVectors, 1'b0);
		cpuWrite(24'h3A0003, 2'b01, 16'h0000);
		checkBit("systemVectors set", systemVectors, 1'b1);
		cpuWrite(24'h3A001B, 2'b01, 16'h0000);
		checkBit("nSystem set", nSystem, 1'b1);  // Cartridge fix ROM
		cpuWrite(24'h3A000B, 2'b01, 16'h0000);
		checkBit("nSystem cleared", nSystem, 1'b0);
		ledWord  = 16'(nextRand());
		coinWord = 16'(nextRand());
		cpuWrite(24'h380031, 2'b01, ledWord);
		checkWord("ledData", {8'h00, ledData}, {8'h00, ledWord[7:0]});
		cpuWrite(24'h380011, 2'b01, coinWord);
		checkWord("coinOut", {12'h000, coinOut}, {12'h000, coinWord[3:0]});
		checkWord("ledData after coin write", {8'h00, ledData}, {8'h00, ledWord[7:0]});
	endtask

	task automatic testWatchdog();
		int firstHigh;
		int highCount;
		cpuWrite(24'h300000, 2'b11, 16'h0000);  // Kick restarts the count at 0
		firstHigh = -1;
		highCount = 0;
		for (int i = 1; i <= 80; i++)
		begin
			@(negedge MCLK);
			if (watchdogReset)
			begin
				highCount++;
				if (firstHigh < 0)
					firstHigh = i;
			end
		end
		checkWord("watchdogReset high cycles", 16'(highCount), 16'd1);
		checkWord("watchdogReset delay", 16'(firstHigh), 16'(wdLimit));
		highCount = 0;
		repeat (5)
		begin
			cpuWrite(24'h300000, 2'b11, 16'h0000);
			repeat (28)
			begin
				@(negedge MCLK);
				if (watchdogReset)
					highCount++;
			end
		end
		checkWord("watchdogReset with kicks", 16'(highCount), 16'd0);
	endtask

	task automatic testRandomBus();
		logic [31:0]         r;
		logic [23:0]         a;
		logic [1:0]          lanes;
		logic                rd;
		neoBusPkg::busZone_e z;
		repeat (48)
		begin
			r     = nextRand();
			a     = r[23:0];
			rd    = r[24];
			lanes = (r[26:25] == 2'b00) ? 2'b11 : r[26:25];
			z     = zoneOf(a);
			if (z == neoBusPkg::zoneSysLatch)
				rd = 1'b1;  // SRAM stays locked
			if (rd)
				cpuRead(a, lanes);
			else
				cpuWrite(a, lanes, r[31:16]);
			checkZone("random zone", seenZone, z);
			checkStrobes("random strobes", seenStrobes, expectStrobes(z, rd, lanes, 1'b1));
			checkBit("random dataOutEnable", seenOe, rd && (z == neoBusPkg::zoneCtrl1 ||
				z == neoBusPkg::zoneCtrl2 || z == neoBusPkg::zoneStatusB));
		end
	endtask

	initial
	begin
		MCLK      = 1'b0;
		reset     = 1'b1;
		cpuAddr   = '0;
		cpuDataIn = 16'h0000;
		p1In      = '1;  // Inputs idle high
		p2In      = '1;
		dipSwitch = '1;
		{rw, nAs, nLds, nUds, nWp, nCd1, nCd2, systemMode} = 8'hFF;
		repeat (4) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
		testStrobes();
		testSramLock();
		testInputs();
		testLatches();
		testWatchdog();
		testRandomBus();
		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
